// File: Bender.yml
package:
  name: sm83_alu

sources:
  # RTL in compile order, the package first.
  - files:
      - verilog/sm83_pkg.sv
      - verilog/sm83_alu_control.sv
      - verilog/sm83_alu_core.sv
      - verilog/sm83_alu_regs.sv
      - verilog/sm83_alu.sv

  # Testbench, built only for simulation.
  - target: test
    files:
      - bench/tb_sm83_alu.sv

// File: bench/sm83_alu_stim.txt
# kind op543 a b expected_result expected_flags expected_cond gap, all hex
# kind 0 alu, 1 shift, 2 daa, 3 condition; gap 1 leaves exec low for one cycle after the line
0 0 0F 01 10 20 0 1
0 0 FF 01 00 B0 0 0
0 1 00 00 01 00 0 0
0 0 80 80 00 90 0 0
0 1 0F 00 10 20 0 1
0 1 FE 01 FF 00 0 0
0 2 10 01 0F 60 0 0
0 2 01 02 FF 70 0 0
0 3 05 02 02 40 0 0
0 3 00 00 00 C0 0 0
0 2 00 01 FF 70 0 0
0 3 10 00 0F 60 0 1
0 7 42 42 42 C0 0 0
0 7 20 01 20 60 0 0
0 7 42 50 42 50 0 0
0 4 F0 0F 00 A0 0 0
0 2 00 01 FF 70 0 0
0 4 3C 0F 0C 20 0 0
0 2 00 01 FF 70 0 0
0 5 FF 0F F0 00 0 0
0 5 5A 5A 00 80 0 0
0 2 00 01 FF 70 0 0
0 6 00 00 00 80 0 0
0 6 81 18 99 00 0 1
1 0 81 00 03 10 0 0
1 0 40 00 80 00 0 0
1 1 81 00 C0 10 0 0
1 1 02 00 01 00 0 0
1 2 80 00 00 90 0 0
1 2 01 00 03 00 0 0
1 3 01 00 00 90 0 0
1 3 80 00 C0 00 0 0
1 4 81 00 02 10 0 0
1 4 00 00 00 80 0 0
1 5 81 00 C0 10 0 0
1 5 7E 00 3F 00 0 0
1 4 80 00 00 90 0 0
1 6 F1 00 1F 00 0 0
1 6 00 00 00 80 0 0
1 7 81 00 40 10 0 0
1 7 01 00 00 90 0 1
0 0 15 27 3C 00 0 0
2 0 3C 00 42 00 0 1
0 0 09 08 11 20 0 0
2 0 11 00 17 00 0 1
0 0 50 70 C0 00 0 0
2 0 C0 00 20 10 0 1
0 0 90 90 20 10 0 0
2 0 20 00 80 10 0 1
0 0 99 01 9A 00 0 0
2 0 9A 00 00 90 0 1
0 0 90 05 95 00 0 0
2 0 95 00 95 00 0 1
0 0 88 88 10 30 0 0
2 0 10 00 76 10 0 1
0 0 12 34 46 00 0 0
2 0 46 00 46 00 0 0
0 0 FF 01 00 B0 0 0
3 0 00 00 00 B0 0 0
3 1 00 00 00 B0 1 0
3 2 00 00 00 B0 0 0
3 3 00 00 00 B0 1 1
0 0 01 01 02 00 1 0
3 0 00 00 02 00 1 0
3 1 00 00 02 00 0 0
3 2 00 00 02 00 1 0
3 3 00 00 02 00 0 1
0 0 00 00 00 80 0 0
3 2 00 00 00 80 1 0
0 1 00 00 00 80 1 0
3 1 00 00 00 80 1 0

// File: bench/tb_sm83_alu.sv
`timescale 1ns/1ps

module tb_sm83_alu;

	logic               clk;
	logic               arst_n;
	logic               exec;
	sm83_pkg::op_kind_t kind;
	logic [2:0]         op543;
	logic [7:0]         a;
	logic [7:0]         b;
	logic [7:0]         result;
	sm83_pkg::flags_t   flags;
	logic               cond_result;

	sm83_pkg::op_kind_t v_kind[$];   // operation class of each vector.
	logic [2:0]         v_op[$];     // op543 of each vector.
	logic [7:0]         v_a[$];      // first operand.
	logic [7:0]         v_b[$];      // second operand.
	logic [7:0]         v_result[$]; // expected result byte one cycle after exec.
	sm83_pkg::flags_t   v_flags[$];  // expected F register one cycle after exec.
	logic               v_cond[$];   // expected condition output that holds between checks.
	logic               v_gap[$];    // exec drops for one cycle after this vector.

	int   mismatches    = 0;    // wrong values seen on the outputs.
	int   file_errors   = 0;    // problems with the stimulus file.
	int   cycles        = 0;    // clock edges since time zero.
	int   cycle_limit   = 40;   // raised once the vectors are known.
	int   cur_idx       = 0;    // vector currently on the inputs.
	int   check_idx     = 0;    // vector whose outputs are due at the next falling edge.
	logic check_pending = 1'b0; // the DUT captured a vector at the last rising edge.

	sm83_alu dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.exec        (exec),
		.kind        (kind),
		.op543       (op543),
		.a           (a),
		.b           (b),
		.result      (result),
		.flags       (flags),
		.cond_result (cond_result)
	);

	// Readable name of an operation for the error lines.
	function automatic string op_name(input sm83_pkg::op_kind_t k, input logic [2:0] op);
		string names; // space separated mnemonics of the group.

		case (k)
			sm83_pkg::KIND_ALU:   names = "add adc sub sbc and xor or  cp  ";
			sm83_pkg::KIND_SHIFT: names = "rlc rrc rl  rr  sla sra swapsrl ";
			sm83_pkg::KIND_DAA:   names = "daa daa daa daa daa daa daa daa ";
			default:              names = "nz  z   nc  c   nz  z   nc  c   ";
		endcase
		return names.substr(op * 4, op * 4 + 3); // four characters per mnemonic.
	endfunction

	task automatic check_result(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: %s result is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flags(input sm83_pkg::flags_t got, input sm83_pkg::flags_t exp,
		input string what);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: %s flags are %h (znhc %b), expected %h (znhc %b)",
				$time, what, got.raw, {got.f.z, got.f.n, got.f.h, got.f.c},
				exp.raw, {exp.f.z, exp.f.n, exp.f.h, exp.f.c});
		end
	endtask

	task automatic check_cond(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: %s cond_result is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Lines that do not start with a hex field are comments and are skipped whole.
	task automatic load_vectors();
		int               fd;
		int               fields;
		logic             reading;
		string            rest;
		logic [7:0]       f_kind;
		logic [7:0]       f_op;
		logic [7:0]       f_a;
		logic [7:0]       f_b;
		logic [7:0]       f_res;
		logic [7:0]       f_flg;
		logic [7:0]       f_cond;
		logic [7:0]       f_gap;
		sm83_pkg::flags_t f_flags;

		fd = $fopen("bench/sm83_alu_stim.txt", "r");
		if (fd == 0) begin
			file_errors++;
			$display("Error: the stimulus file bench/sm83_alu_stim.txt cannot be opened.");
		end else begin
			reading = 1'b1;
			while (reading) begin
				fields = $fscanf(fd, " %h %h %h %h %h %h %h %h",
					f_kind, f_op, f_a, f_b, f_res, f_flg, f_cond, f_gap);
				if (fields == 8) begin
					f_flags.raw = f_flg;
					v_kind.push_back(sm83_pkg::op_kind_t'(f_kind[1:0]));
					v_op.push_back(f_op[2:0]);
					v_a.push_back(f_a);
					v_b.push_back(f_b);
					v_result.push_back(f_res);
					v_flags.push_back(f_flags);
					v_cond.push_back(f_cond[0]);
					v_gap.push_back(f_gap[0]);
				end else if (fields < 0) begin
					reading = 1'b0; // end of file.
				end else begin
					if (fields > 0) begin
						file_errors++;
						$display("Error: the stimulus line after vector %0d has %0d fields, not 8.",
							v_a.size(), fields);
					end
					if ($fgets(rest, fd) == 0) begin
						reading = 1'b0;
					end
				end
			end
			$fclose(fd);
			if (v_a.size() == 0) begin
				file_errors++;
				$display("Error: the stimulus file holds no vectors.");
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period.
	end

	// Hard stop in case the DUT or the sequence below stalls.
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Error: timeout, the run went past %0d clock cycles.", cycle_limit);
			$display("errors: %0d mismatches, %0d stimulus file problems", mismatches,
				file_errors);
			$display("Something failed");
			$finish;
		end
	end

	// The DUT loads on the edge where exec is high, so the outputs are checked half a cycle later.
	always @(posedge clk) begin
		check_pending <= exec;
		check_idx     <= cur_idx;
	end

	always @(negedge clk) begin
		string what; // operation and operands of the vector under check.

		if (check_pending) begin
			what = $sformatf("%s a=%h b=%h (vector %0d)", op_name(v_kind[check_idx],
				v_op[check_idx]), v_a[check_idx], v_b[check_idx], check_idx);
			check_result(result, v_result[check_idx], what);
			check_flags(flags, v_flags[check_idx], what);
			check_cond(cond_result, v_cond[check_idx], what);
		end
	end

	initial begin
		arst_n = 1'b0;
		exec   = 1'b0;
		kind   = sm83_pkg::KIND_ALU;
		op543  = 3'd0;
		a      = 8'h00;
		b      = 8'h00;
		load_vectors();
		cycle_limit = v_a.size() * 3 + 40; // at most two cycles per vector plus reset.
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_result(result, 8'h00, "reset");
		check_flags(flags, sm83_pkg::flags_t'(8'h00), "reset");
		check_cond(cond_result, 1'b0, "reset");
		for (int i = 0; i < v_a.size(); i++) begin
			@(posedge clk);
			kind    <= v_kind[i];
			op543   <= v_op[i];
			a       <= v_a[i];
			b       <= v_b[i];
			exec    <= 1'b1;
			cur_idx <= i;
			if (v_gap[i]) begin
				@(posedge clk);
				exec <= 1'b0; // one idle cycle between operations.
			end
		end
		@(posedge clk);
		exec <= 1'b0;
		repeat (3) @(negedge clk);
		$display("errors: %0d mismatches, %0d stimulus file problems", mismatches, file_errors);
		if (mismatches == 0 && file_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: list.f
verilog/sm83_pkg.sv
verilog/sm83_alu_control.sv
verilog/sm83_alu_core.sv
verilog/sm83_alu_regs.sv
verilog/sm83_alu.sv
bench/tb_sm83_alu.sv

// File: verilog/sm83_alu.sv
`timescale 1ns/1ps

module sm83_alu (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               exec,       // one cycle pulse that starts an operation.
	input  sm83_pkg::op_kind_t kind,       // operation class.
	input  logic [2:0]         op543,      // bits 5:3 of the opcode.
	input  logic [7:0]         a,          // accumulator or shift operand.
	input  logic [7:0]         b,          // second alu operand.
	output logic [7:0]         result,     // registered result that is valid one cycle after exec.
	output sm83_pkg::flags_t   flags,      // F register that is valid one cycle after exec.
	output logic               cond_result // registered condition outcome.
);

	logic             shift_dbh;      // msb of a towards the control block.
	logic             shift_dbl;      // lsb of a towards the control block.
	logic             daa_l_gt_9;     // low nibble comparator.
	logic             daa_h_gt_9;     // high nibble comparator.
	logic             daa_h_eq_9;     // high nibble equals 9.
	logic [7:0]       daa_out;        // decimal correction.
	logic             daa_carry_out;  // carry after daa.
	logic             shift_out;      // bit leaving the word.
	logic             shift_into_alu; // bit entering the word.
	logic             shift_l;        // left shift strobe.
	logic             shift_r;        // right shift strobe.
	logic [7:0]       next_result;    // core result before the register.
	sm83_pkg::flags_t next_flags;     // core flags before the register.

	// Control sees the stored flags so conditions and daa use the previous operation.
	sm83_alu_control u_control (
		.clk            (clk),
		.arst_n         (arst_n),
		.exec           (exec),
		.kind           (kind),
		.op543          (op543),
		.zero           (flags.f.z),
		.carry          (flags.f.c),
		.pri_carry      (flags.f.c),
		.daa_carry      (flags.f.h),
		.shift_dbh      (shift_dbh),
		.shift_dbl      (shift_dbl),
		.daa_l_gt_9     (daa_l_gt_9),
		.daa_h_gt_9     (daa_h_gt_9),
		.daa_h_eq_9     (daa_h_eq_9),
		.daa_out        (daa_out),
		.daa_carry_out  (daa_carry_out),
		.shift_out      (shift_out),
		.shift_into_alu (shift_into_alu),
		.shift_l        (shift_l),
		.shift_r        (shift_r),
		.cond_result    (cond_result)
	);

	sm83_alu_core u_core (
		.kind           (kind),
		.op543          (op543),
		.a              (a),
		.b              (b),
		.flags_in       (flags),
		.shift_l        (shift_l),
		.shift_r        (shift_r),
		.shift_into_alu (shift_into_alu),
		.shift_out      (shift_out),
		.daa_out        (daa_out),
		.daa_carry_out  (daa_carry_out),
		.shift_dbh      (shift_dbh),
		.shift_dbl      (shift_dbl),
		.daa_l_gt_9     (daa_l_gt_9),
		.daa_h_gt_9     (daa_h_gt_9),
		.daa_h_eq_9     (daa_h_eq_9),
		.next_result    (next_result),
		.next_flags     (next_flags)
	);

	sm83_alu_regs u_regs (
		.clk         (clk),
		.arst_n      (arst_n),
		.exec        (exec),
		.kind        (kind),
		.next_result (next_result),
		.next_flags  (next_flags),
		.result      (result),
		.flags       (flags)
	);

endmodule

// File: verilog/sm83_alu_control.sv
`timescale 1ns/1ps

module sm83_alu_control (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               exec,           // one cycle pulse that starts an operation.
	input  sm83_pkg::op_kind_t kind,           // class of the current operation.
	input  logic [2:0]         op543,          // bits 5:3 of the opcode.
	input  logic               zero,           // z flag as it stands before this operation.
	input  logic               carry,          // c flag used for the branch conditions.
	input  logic               pri_carry,      // c flag used by rl, rr and the daa rule.
	input  logic               daa_carry,      // h flag that forces the low digit correction.
	input  logic               shift_dbh,      // msb of a leaving on a left shift.
	input  logic               shift_dbl,      // lsb of a leaving on a right shift.
	input  logic               daa_l_gt_9,     // low nibble of a is above 9.
	input  logic               daa_h_gt_9,     // high nibble of a is above 9.
	input  logic               daa_h_eq_9,     // high nibble of a is exactly 9.
	output logic [7:0]         daa_out,        // correction of 0x00, 0x06, 0x60 or 0x66.
	output logic               daa_carry_out,  // carry flag after daa.
	output logic               shift_out,      // bit that leaves the word and becomes the new carry.
	output logic               shift_into_alu, // bit that enters the vacated end.
	output logic               shift_l,        // shift the word one place left.
	output logic               shift_r,        // shift the word one place right.
	output logic               cond_result     // registered outcome of the last condition.
);

	logic is_shift;  // shift group is active this cycle.
	logic cond_next; // condition picked by op543 from the current flags.

	assign is_shift = (kind == sm83_pkg::KIND_SHIFT);

	// Odd codes in the shift group move right and even codes move left.
	assign shift_l = is_shift && !op543[0]; // swap lands here too but the core ignores it.
	assign shift_r = is_shift && op543[0];

	always_comb begin
		case (op543)
			sm83_pkg::SH_RLC, sm83_pkg::SH_SRA: shift_into_alu = shift_dbh; // msb wraps or repeats.
			sm83_pkg::SH_RRC:                   shift_into_alu = shift_dbl; // lsb wraps to the top.
			sm83_pkg::SH_RL, sm83_pkg::SH_RR:   shift_into_alu = pri_carry; // nine bit rotate.
			default:                            shift_into_alu = 1'b0;      // sla, srl and swap.
		endcase
	end

	assign shift_out = op543[0] ? shift_dbl : shift_dbh; // the end that falls off the word.

	always_comb begin
		case (op543[1:0])
			sm83_pkg::COND_NZ: cond_next = !zero;
			sm83_pkg::COND_Z:  cond_next = zero;
			sm83_pkg::COND_NC: cond_next = !carry;
			default:           cond_next = carry; // cond_c.
		endcase
	end

	// The condition is sampled from the flags as they stand before this edge.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cond_result <= 1'b0;
		end else if (exec && kind == sm83_pkg::KIND_COND) begin
			cond_result <= cond_next;
		end
	end

	// DAA correction built from the nibble comparators and the old h and c flags.
	always_comb begin
		logic [7:0] corr; // correction value under construction.
		logic       hi;   // the high digit needs fixing.

		corr = 8'h00;
		if (daa_l_gt_9 || daa_carry) begin
			corr = corr | sm83_pkg::DAA_LO; // low digit overflowed or carried.
		end
		hi = pri_carry || daa_h_gt_9 || (daa_h_eq_9 && daa_l_gt_9); // 0x9a and up spill too.
		if (hi) begin
			corr = corr | sm83_pkg::DAA_HI;
		end
		daa_out       = corr;
		daa_carry_out = hi; // decimal carry out of the byte.
	end

endmodule

// File: verilog/sm83_alu_core.sv
`timescale 1ns/1ps

module sm83_alu_core (
	input  sm83_pkg::op_kind_t kind,           // class of the current operation.
	input  logic [2:0]         op543,          // bits 5:3 of the opcode.
	input  logic [7:0]         a,              // accumulator or shift operand.
	input  logic [7:0]         b,              // second operand of the alu group.
	input  sm83_pkg::flags_t   flags_in,       // F register before this operation.
	input  logic               shift_l,        // shift left by one place.
	input  logic               shift_r,        // shift right by one place.
	input  logic               shift_into_alu, // bit entering the vacated end.
	input  logic               shift_out,      // bit leaving the word.
	input  logic [7:0]         daa_out,        // decimal correction value.
	input  logic               daa_carry_out,  // carry flag after daa.
	output logic               shift_dbh,      // msb of a.
	output logic               shift_dbl,      // lsb of a.
	output logic               daa_l_gt_9,     // low nibble of a above 9.
	output logic               daa_h_gt_9,     // high nibble of a above 9.
	output logic               daa_h_eq_9,     // high nibble of a equal to 9.
	output logic [7:0]         next_result,    // value to load into the result register.
	output sm83_pkg::flags_t   next_flags      // value to load into the F register.
);

	logic       is_sub;    // sub, sbc and cp run the adder as a subtractor.
	logic       use_carry; // adc and sbc fold the old carry in.
	logic [7:0] b_eff;     // b as it reaches the adder, inverted for a subtraction.
	logic       c_in;      // carry into bit 0 of the adder.
	logic [4:0] sum_lo;    // low nibble sum with its carry into bit 4.
	logic [4:0] sum_hi;    // high nibble sum with its carry out of bit 7.
	logic [7:0] arith;     // full add or subtract result.
	logic       half;      // h as the sm83 reports it.
	logic       full;      // c as the sm83 reports it.
	logic [7:0] shifted;   // a moved one place with the fill bit.
	logic [7:0] daa_sum;   // a after the decimal correction.

	// The sm83 builds its byte adder from two of these 4-bit slices.
	function automatic logic [4:0] add_nibble(input logic [3:0] x, input logic [3:0] y,
		input logic ci);
		add_nibble = {1'b0, x} + {1'b0, y} + {4'b0000, ci};
	endfunction

	assign shift_dbh  = a[7];
	assign shift_dbl  = a[0];
	assign daa_l_gt_9 = (a[3:0] > 4'd9);
	assign daa_h_gt_9 = (a[7:4] > 4'd9);
	assign daa_h_eq_9 = (a[7:4] == 4'd9);

	assign is_sub    = (op543 == sm83_pkg::ALU_SUB) || (op543 == sm83_pkg::ALU_SBC) ||
		(op543 == sm83_pkg::ALU_CP);
	assign use_carry = (op543 == sm83_pkg::ALU_ADC) || (op543 == sm83_pkg::ALU_SBC);

	// Subtraction is a plus the complement of b with the carry sense inverted.
	assign b_eff  = is_sub ? ~b : b;
	assign c_in   = (use_carry & flags_in.f.c) ^ is_sub;
	assign sum_lo = add_nibble(a[3:0], b_eff[3:0], c_in);
	assign sum_hi = add_nibble(a[7:4], b_eff[7:4], sum_lo[4]);
	assign arith  = {sum_hi[3:0], sum_lo[3:0]};
	assign half   = sum_lo[4] ^ is_sub; // a missing carry out of the low nibble means a borrow.
	assign full   = sum_hi[4] ^ is_sub;

	always_comb begin
		if (shift_r) begin
			shifted = {shift_into_alu, a[7:1]};
		end else if (shift_l) begin
			shifted = {a[6:0], shift_into_alu};
		end else begin
			shifted = a;
		end
	end

	// After a subtraction the same correction is taken off instead of added.
	assign daa_sum = flags_in.f.n ? (a - daa_out) : (a + daa_out);

	always_comb begin
		next_result = a;        // cond and cp keep the accumulator.
		next_flags  = flags_in; // a condition check changes nothing.
		case (kind)
			sm83_pkg::KIND_ALU: begin
				next_flags.f.n = is_sub;
				case (op543)
					sm83_pkg::ALU_AND: begin
						next_result    = a & b;
						next_flags.f.h = 1'b1; // and always reports a half carry.
						next_flags.f.c = 1'b0;
					end
					sm83_pkg::ALU_XOR: begin
						next_result    = a ^ b;
						next_flags.f.h = 1'b0;
						next_flags.f.c = 1'b0;
					end
					sm83_pkg::ALU_OR: begin
						next_result    = a | b;
						next_flags.f.h = 1'b0;
						next_flags.f.c = 1'b0;
					end
					sm83_pkg::ALU_CP: begin
						next_flags.f.h = half;
						next_flags.f.c = full;
					end
					default: begin
						next_result    = arith; // add, adc, sub and sbc.
						next_flags.f.h = half;
						next_flags.f.c = full;
					end
				endcase
				// cp reports z from the difference, so z is set when a equals b.
				next_flags.f.z = (op543 == sm83_pkg::ALU_CP) ? (arith == 8'h00) :
					(next_result == 8'h00);
			end
			sm83_pkg::KIND_SHIFT: begin
				if (op543 == sm83_pkg::SH_SWAP) begin
					next_result    = {a[3:0], a[7:4]};
					next_flags.f.c = 1'b0; // nothing leaves the word on a swap.
				end else begin
					next_result    = shifted;
					next_flags.f.c = shift_out;
				end
				next_flags.f.n = 1'b0;
				next_flags.f.h = 1'b0;
				next_flags.f.z = (next_result == 8'h00);
			end
			sm83_pkg::KIND_DAA: begin
				next_result    = daa_sum;
				next_flags.f.h = 1'b0;            // n is left as it was.
				next_flags.f.c = daa_carry_out;
				next_flags.f.z = (daa_sum == 8'h00);
			end
			default: begin
			end
		endcase
	end

endmodule

// File: verilog/sm83_alu_regs.sv
`timescale 1ns/1ps

module sm83_alu_regs (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               exec,        // one cycle pulse that starts an operation.
	input  sm83_pkg::op_kind_t kind,        // class of the current operation.
	input  logic [7:0]         next_result, // result computed by the core.
	input  sm83_pkg::flags_t   next_flags,  // flags computed by the core.
	output logic [7:0]         result,      // registered result byte.
	output sm83_pkg::flags_t   flags        // F register.
);

	logic load; // an operation that writes back is running this cycle.

	// A condition check only reads the flags, so it leaves both registers alone.
	assign load = exec && (kind != sm83_pkg::KIND_COND);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result <= 8'h00;
		end else if (load) begin
			result <= next_result;
		end
	end

	// The low nibble of F has no storage on the sm83 and always reads back zero.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags.raw <= 8'h00;
		end else if (load) begin
			flags.raw <= {next_flags.raw[7:4], 4'h0};
		end
	end

endmodule

// File: verilog/sm83_pkg.sv
package sm83_pkg;

	// Operation class presented together with the exec strobe.
	typedef enum logic [1:0] {
		KIND_ALU   = 2'd0, // accumulator operations selected by op543.
		KIND_SHIFT = 2'd1, // cb prefix rotates and shifts selected by op543.
		KIND_DAA   = 2'd2, // decimal adjust of the accumulator.
		KIND_COND  = 2'd3  // branch condition check that leaves a and f alone.
	} op_kind_t;

	// Accumulator operations, bits 5:3 of the 8-bit opcode.
	localparam logic [2:0] ALU_ADD = 3'd0; // a plus b.
	localparam logic [2:0] ALU_ADC = 3'd1; // a plus b plus carry.
	localparam logic [2:0] ALU_SUB = 3'd2; // a minus b.
	localparam logic [2:0] ALU_SBC = 3'd3; // a minus b minus carry.
	localparam logic [2:0] ALU_AND = 3'd4; // bitwise and that sets h.
	localparam logic [2:0] ALU_XOR = 3'd5; // bitwise exclusive or.
	localparam logic [2:0] ALU_OR  = 3'd6; // bitwise or.
	localparam logic [2:0] ALU_CP  = 3'd7; // compare by a subtraction that drops the result.

	// CB prefix rotate and shift group, bits 5:3 of the second opcode byte.
	localparam logic [2:0] SH_RLC  = 3'd0; // rotate left through bit 0.
	localparam logic [2:0] SH_RRC  = 3'd1; // rotate right through bit 7.
	localparam logic [2:0] SH_RL   = 3'd2; // rotate left through the carry flag.
	localparam logic [2:0] SH_RR   = 3'd3; // rotate right through the carry flag.
	localparam logic [2:0] SH_SLA  = 3'd4; // arithmetic shift left.
	localparam logic [2:0] SH_SRA  = 3'd5; // arithmetic shift right keeping the sign.
	localparam logic [2:0] SH_SWAP = 3'd6; // exchange the two nibbles.
	localparam logic [2:0] SH_SRL  = 3'd7; // logical shift right.

	// Conditions in op543 bits 1:0 for jr, jp, call and ret.
	localparam logic [1:0] COND_NZ = 2'd0; // taken when z is clear.
	localparam logic [1:0] COND_Z  = 2'd1; // taken when z is set.
	localparam logic [1:0] COND_NC = 2'd2; // taken when c is clear.
	localparam logic [1:0] COND_C  = 2'd3; // taken when c is set.

	// The two halves of the decimal adjust correction.
	localparam logic [7:0] DAA_LO = 8'h06; // fixes the low bcd digit.
	localparam logic [7:0] DAA_HI = 8'h60; // fixes the high bcd digit.

	// F register seen as named flags by the datapath and as a byte by push af and pop af.
	typedef union packed {
		struct packed {
			logic       z;    // result was zero.
			logic       n;    // last operation was a subtraction.
			logic       h;    // carry or borrow across bit 3.
			logic       c;    // carry or borrow across bit 7.
			logic [3:0] rsvd; // always reads as zero on the sm83.
		} f;
		logic [7:0] raw;
	} flags_t;

endpackage
